/* ext_mem.f */
ext_mem_pkg.sv
ext_mem_bus_decode.sv
ext_mem_byte_lane.sv
ext_mem_read_pipe.sv
ext_mem_top.sv
ext_mem_checker.sv
ext_mem_tb.sv

/* ext_mem_tb.sv */
// testbench top: clock, reset, LFSR, stimulus table and the loop that applies it
`timescale 1ns/1ps
`default_nettype none

module ext_mem_tb;

   import ext_mem_pkg::*;

   localparam int          MAX_ROWS       = 96;
   localparam int          NUM_RAND_PAIRS = 16;
   localparam int          DRAIN_TIMEOUT  = 40;
   localparam logic [31:0] LFSR_SEED      = 32'hd580;
   localparam logic [31:0] LFSR_TAPS      = 32'h80200003;

   typedef enum logic [1:0] {
      ROW_IDLE,
      ROW_READ,
      ROW_WRITE,
      ROW_BOTH
   } row_kind_t;

   // one bus cycle of stimulus
   typedef struct packed {
      row_kind_t                kind;
      logic                     cs;
      logic [MEM_ADDR_W-1:0]    addr;
      logic [MEM_NUM_LANES-1:0] be;
      logic [MEM_DATA_W-1:0]    data;
      logic                     oe;
   } row_t;

   logic                     clk;
   logic                     internal_reset;
   logic [MEM_ADDR_W-1:0]    bus_address;
   logic [MEM_DATA_W-1:0]    bus_write_data;
   logic [MEM_NUM_LANES-1:0] bus_byteenable;
   logic                     bus_read;
   logic                     bus_write;
   logic                     bus_chipselect_n;
   logic                     bus_outputenable;
   logic [MEM_DATA_W-1:0]    rd_data;
   logic                     rd_valid;
   logic                     end_of_test;
   int                       mismatch_count;
   int                       stray_count;
   int                       leftover_count;
   int                       pending_count;
   int                       timeout_count;
   int                       wait_cycles;
   int                       num_rows;
   row_t                     rows [MAX_ROWS];
   logic [31:0]              lfsr_state;

   ext_mem_top i_dut (
      .clk              (clk),
      .internal_reset   (internal_reset),
      .bus_address      (bus_address),
      .bus_write_data   (bus_write_data),
      .bus_byteenable   (bus_byteenable),
      .bus_read         (bus_read),
      .bus_write        (bus_write),
      .bus_chipselect_n (bus_chipselect_n),
      .bus_outputenable (bus_outputenable),
      .rd_data          (rd_data),
      .rd_valid         (rd_valid)
   );

   ext_mem_checker i_checker (
      .clk              (clk),
      .internal_reset   (internal_reset),
      .bus_address      (bus_address),
      .bus_write_data   (bus_write_data),
      .bus_byteenable   (bus_byteenable),
      .bus_read         (bus_read),
      .bus_write        (bus_write),
      .bus_chipselect_n (bus_chipselect_n),
      .bus_outputenable (bus_outputenable),
      .rd_data          (rd_data),
      .rd_valid         (rd_valid),
      .end_of_test      (end_of_test),
      .mismatch_count   (mismatch_count),
      .stray_count      (stray_count),
      .leftover_count   (leftover_count),
      .pending_count    (pending_count)
   );

   // 4 ns period
   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // ----------------------------------------
   // random bits and table building
   // ----------------------------------------

   // galois step, the bit shifted out is the random bit
   function automatic logic [31:0] random_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v = {v[30:0], lfsr_state[0]};
         lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? LFSR_TAPS : 32'h0);
      end
      return v;
   endfunction

   task automatic add_row(input row_kind_t kind, input logic cs, input logic [9:0] addr,
                          input logic [3:0] be, input logic [31:0] data, input logic oe);
      row_t r;
      r.kind = kind;
      r.cs   = cs;
      r.addr = addr;
      r.be   = be;
      r.data = data;
      r.oe   = oe;
      if (num_rows < MAX_ROWS) begin
         rows[num_rows] = r;
         num_rows++;
      end else begin
         $display("stimulus table full, row dropped");
         timeout_count++;
      end
   endtask

   task automatic build_table();
      logic [31:0] w;
      logic [31:0] lo;
      logic [31:0] d;
      // fresh memory reads zero, one spaced read then two back to back
      add_row(ROW_READ,  1'b1, 10'h000, 4'hf, 32'h0, 1'b1);
      add_row(ROW_IDLE,  1'b0, 10'h000, 4'h0, 32'h0, 1'b0);
      add_row(ROW_READ,  1'b1, 10'h104, 4'hf, 32'h0, 1'b1);
      add_row(ROW_READ,  1'b1, 10'h3fc, 4'hf, 32'h0, 1'b1);
      // full writes, then a burst of reads
      add_row(ROW_WRITE, 1'b1, 10'h010, 4'hf, 32'h11223344, 1'b0);
      add_row(ROW_WRITE, 1'b1, 10'h014, 4'hf, 32'hcafef00d, 1'b0);
      add_row(ROW_WRITE, 1'b1, 10'h018, 4'hf, 32'h0badbeef, 1'b0);
      add_row(ROW_READ,  1'b1, 10'h018, 4'hf, 32'h0, 1'b1);
      add_row(ROW_READ,  1'b1, 10'h010, 4'hf, 32'h0, 1'b1);
      add_row(ROW_READ,  1'b1, 10'h014, 4'hf, 32'h0, 1'b1);
      // partial writes and partial reads
      add_row(ROW_WRITE, 1'b1, 10'h010, 4'b0101, 32'haabbccdd, 1'b0);
      add_row(ROW_WRITE, 1'b1, 10'h014, 4'b1000, 32'h5a000000, 1'b0);
      add_row(ROW_READ,  1'b1, 10'h010, 4'hf, 32'h0, 1'b1);
      add_row(ROW_READ,  1'b1, 10'h010, 4'b0011, 32'h0, 1'b1);
      add_row(ROW_READ,  1'b1, 10'h014, 4'b1100, 32'h0, 1'b1);
      // chip select off or output enable low, nothing comes back
      add_row(ROW_READ,  1'b0, 10'h010, 4'hf, 32'h0, 1'b1);
      add_row(ROW_READ,  1'b1, 10'h014, 4'hf, 32'h0, 1'b0);
      add_row(ROW_WRITE, 1'b0, 10'h018, 4'hf, 32'hffffffff, 1'b0);
      add_row(ROW_READ,  1'b1, 10'h018, 4'hf, 32'h0, 1'b1);
      // both strobes up is a write
      add_row(ROW_BOTH,  1'b1, 10'h01c, 4'hf, 32'h76543210, 1'b1);
      add_row(ROW_READ,  1'b1, 10'h01c, 4'hf, 32'h0, 1'b1);
      // byte-select bits do not change the word
      add_row(ROW_WRITE, 1'b1, 10'h02b, 4'hf, 32'h13579bdf, 1'b0);
      add_row(ROW_READ,  1'b1, 10'h028, 4'hf, 32'h0, 1'b1);
      add_row(ROW_READ,  1'b1, 10'h02a, 4'hf, 32'h0, 1'b1);
      add_row(ROW_READ,  1'b1, 10'h011, 4'b0110, 32'h0, 1'b1);
      // random write then read of the same word
      for (int p = 0; p < NUM_RAND_PAIRS; p++) begin
         w  = random_bits(8);
         lo = random_bits(2);
         d  = random_bits(32);
         add_row(ROW_WRITE, 1'b1, {w[7:0], lo[1:0]}, 4'hf, d, 1'b0);
         lo = random_bits(2);
         add_row(ROW_READ, 1'b1, {w[7:0], lo[1:0]}, 4'hf, 32'h0, 1'b1);
      end
      // quiet tail so the bus ends idle
      for (int i = 0; i < 4; i++) begin
         add_row(ROW_IDLE, 1'b0, 10'h000, 4'h0, 32'h0, 1'b0);
      end
   endtask

   task automatic drive_row(input row_t r);
      bus_address      <= r.addr;
      bus_write_data   <= r.data;
      bus_byteenable   <= r.be;
      bus_read         <= (r.kind == ROW_READ) || (r.kind == ROW_BOTH);
      bus_write        <= (r.kind == ROW_WRITE) || (r.kind == ROW_BOTH);
      bus_chipselect_n <= !r.cs;
      bus_outputenable <= r.oe;
   endtask

   // ----------------------------------------
   // main sequence
   // ----------------------------------------

   initial begin
      internal_reset   = 1'b1;
      bus_address      = '0;
      bus_write_data   = '0;
      bus_byteenable   = '0;
      bus_read         = 1'b0;
      bus_write        = 1'b0;
      bus_chipselect_n = 1'b1;
      bus_outputenable = 1'b0;
      end_of_test      = 1'b0;
      lfsr_state       = LFSR_SEED;
      num_rows         = 0;
      timeout_count    = 0;
      build_table();
      repeat (16) @(posedge clk);
      internal_reset <= 1'b0;
      // one row per cycle
      for (int i = 0; i < num_rows; i++) begin
         @(posedge clk);
         drive_row(rows[i]);
      end
      // let outstanding reads come back
      wait_cycles = 0;
      while ((pending_count != 0) && (wait_cycles < DRAIN_TIMEOUT)) begin
         @(negedge clk);
         wait_cycles++;
      end
      if (pending_count != 0) begin
         $display("timed out with %0d reads still outstanding", pending_count);
         timeout_count++;
      end
      // idle margin to catch late or stray pulses
      repeat (6) @(negedge clk);
      @(posedge clk);
      end_of_test <= 1'b1;
      repeat (2) @(negedge clk);
      $display("errors: mismatches=%0d stray_valids=%0d leftover_reads=%0d other=%0d",
               mismatch_count, stray_count, leftover_count, timeout_count);
      if ((mismatch_count + stray_count + leftover_count + timeout_count) == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* ext_mem_checker.sv */
// testbench checker: shadow memory, expected read queue and read data compare
`timescale 1ns/1ps
`default_nettype none

module ext_mem_checker (
   input  wire logic                                  clk,
   input  wire logic                                  internal_reset,
   input  wire logic [ext_mem_pkg::MEM_ADDR_W-1:0]    bus_address,
   input  wire logic [ext_mem_pkg::MEM_DATA_W-1:0]    bus_write_data,
   input  wire logic [ext_mem_pkg::MEM_NUM_LANES-1:0] bus_byteenable,
   input  wire logic                                  bus_read,
   input  wire logic                                  bus_write,
   input  wire logic                                  bus_chipselect_n,
   input  wire logic                                  bus_outputenable,
   input  wire logic [ext_mem_pkg::MEM_DATA_W-1:0]    rd_data,
   input  wire logic                                  rd_valid,
   input  wire logic                                  end_of_test,
   output int                                         mismatch_count,
   output int                                         stray_count,
   output int                                         leftover_count,
   output int                                         pending_count
);

   import ext_mem_pkg::*;

   // edges from acceptance to the sample that sees valid, accepting edge counted
   localparam int READ_EDGES = 3;

   logic [MEM_DATA_W-1:0]      shadow [MEM_NUM_WORDS];
   logic [MEM_DATA_W-1:0]      exp_data_q [$];
   int                         exp_edge_q [$];
   int                         edge_count;
   logic                       end_reported;
   logic [MEM_DATA_W-1:0]      exp_word;
   int                         exp_edge;
   logic [MEM_WORD_ADDR_W-1:0] word_idx;
   logic                       cs_on;

   // one byte of ones per enabled lane
   function automatic logic [MEM_DATA_W-1:0] lane_mask(input logic [MEM_NUM_LANES-1:0] be);
      logic [MEM_DATA_W-1:0] m;
      m = '0;
      for (int l = 0; l < MEM_NUM_LANES; l++) begin
         if (be[l]) begin
            m[l*MEM_LANE_W +: MEM_LANE_W] = '1;
         end
      end
      return m;
   endfunction

   initial begin
      mismatch_count = 0;
      stray_count    = 0;
      leftover_count = 0;
      pending_count  = 0;
      end_reported   = 1'b0;
   end

   // ----------------------------------------
   // compare and model, once per edge
   // ----------------------------------------

   always @(posedge clk) begin
      if (internal_reset) begin
         // memory comes out of reset all zero
         for (int i = 0; i < MEM_NUM_WORDS; i++) begin
            shadow[i] = '0;
         end
         exp_data_q.delete();
         exp_edge_q.delete();
         edge_count = 0;
      end else begin
         edge_count++;
         // output side, reflects reads from earlier edges
         if (rd_valid) begin
            if (exp_data_q.size() == 0) begin
               $display("unexpected valid pulse at %0t with no read outstanding", $time);
               stray_count++;
            end else begin
               exp_word = exp_data_q.pop_front();
               exp_edge = exp_edge_q.pop_front();
               if (rd_data !== exp_word) begin
                  $display("CHECK FAILED at %0t: read data %h, expected %h",
                           $time, rd_data, exp_word);
                  mismatch_count++;
               end
               if ((edge_count - exp_edge) != READ_EDGES) begin
                  $display("CHECK FAILED at %0t: valid after %0d edges, expected %0d",
                           $time, edge_count - exp_edge, READ_EDGES);
                  mismatch_count++;
               end
            end
         end else if (rd_data !== '0) begin
            $display("CHECK FAILED at %0t: read data %h while valid is low", $time, rd_data);
            mismatch_count++;
         end
         // bus side, chip select pin is active low
         cs_on    = !bus_chipselect_n;
         word_idx = bus_address[MEM_ADDR_W-1:MEM_LANE_SEL_W];
         if (cs_on && bus_write) begin
            for (int l = 0; l < MEM_NUM_LANES; l++) begin
               if (bus_byteenable[l]) begin
                  shadow[word_idx][l*MEM_LANE_W +: MEM_LANE_W] =
                     bus_write_data[l*MEM_LANE_W +: MEM_LANE_W];
               end
            end
         end else if (cs_on && bus_read && bus_outputenable) begin
            exp_data_q.push_back(shadow[word_idx] & lane_mask(bus_byteenable));
            exp_edge_q.push_back(edge_count);
         end
         // reads that never came back
         if (end_of_test && !end_reported) begin
            if (exp_data_q.size() != 0) begin
               $display("%0d accepted reads never produced a valid pulse", exp_data_q.size());
               leftover_count = exp_data_q.size();
            end
            end_reported = 1'b1;
         end
      end
      pending_count = exp_data_q.size();
   end

endmodule

`default_nettype wire

/* ext_mem_top.sv */
// memory top level: bus decoder, byte lane array and read pipeline
`timescale 1ns/1ps
`default_nettype none

module ext_mem_top (
   input  wire logic                                  clk,
   input  wire logic                                  internal_reset,
   input  wire logic [ext_mem_pkg::MEM_ADDR_W-1:0]    bus_address,
   input  wire logic [ext_mem_pkg::MEM_DATA_W-1:0]    bus_write_data,
   input  wire logic [ext_mem_pkg::MEM_NUM_LANES-1:0] bus_byteenable,
   input  wire logic                                  bus_read,
   input  wire logic                                  bus_write,
   input  wire logic                                  bus_chipselect_n,
   input  wire logic                                  bus_outputenable,
   output logic      [ext_mem_pkg::MEM_DATA_W-1:0]    rd_data,
   output logic                                       rd_valid
);

   import ext_mem_pkg::*;

   // decoder outputs
   bus_op_t                    op;
   logic [MEM_WORD_ADDR_W-1:0] word_addr;
   logic [MEM_NUM_LANES-1:0]   lane_we;
   logic [MEM_NUM_LANES-1:0]   lane_be;
   logic                       rd_drive;

   // lane bytes merged back into one word
   logic [MEM_DATA_W-1:0]      lane_rd_data;

   // ----------------------------------------
   // bus decode
   // ----------------------------------------

   ext_mem_bus_decode i_decode (
      .bus_address      (bus_address),
      .bus_byteenable   (bus_byteenable),
      .bus_read         (bus_read),
      .bus_write        (bus_write),
      .bus_chipselect_n (bus_chipselect_n),
      .bus_outputenable (bus_outputenable),
      .op               (op),
      .word_addr        (word_addr),
      .lane_we          (lane_we),
      .lane_be          (lane_be),
      .rd_drive         (rd_drive)
   );

   // ----------------------------------------
   // byte lanes
   // ----------------------------------------

   // every lane reads on any read, masking happens at the pipeline end
   for (genvar g = 0; g < MEM_NUM_LANES; g++) begin : g_lane
      ext_mem_byte_lane i_lane (
         .clk            (clk),
         .internal_reset (internal_reset),
         .word_addr      (word_addr),
         .we             (lane_we[g]),
         .re             (op == OP_READ),
         .wr_byte        (bus_write_data[g*MEM_LANE_W +: MEM_LANE_W]),
         .rd_byte        (lane_rd_data[g*MEM_LANE_W +: MEM_LANE_W])
      );
   end

   // ----------------------------------------
   // read pipeline
   // ----------------------------------------

   ext_mem_read_pipe i_read_pipe (
      .clk            (clk),
      .internal_reset (internal_reset),
      .lane_rd_data   (lane_rd_data),
      .rd_drive       (rd_drive),
      .lane_be        (lane_be),
      .rd_data        (rd_data),
      .rd_valid       (rd_valid)
   );

endmodule

`default_nettype wire

/* ext_mem_read_pipe.sv */
// read pipeline: latency shift register, byte masking and valid generation
`timescale 1ns/1ps
`default_nettype none

module ext_mem_read_pipe (
   input  wire logic                                 clk,
   input  wire logic                                 internal_reset,
   input  wire logic [ext_mem_pkg::MEM_DATA_W-1:0]   lane_rd_data,
   input  wire logic                                 rd_drive,
   input  wire logic [ext_mem_pkg::MEM_NUM_LANES-1:0] lane_be,
   output logic      [ext_mem_pkg::MEM_DATA_W-1:0]   rd_data,
   output logic                                      rd_valid
);

   import ext_mem_pkg::*;

   // flag and enables held for the one edge the lanes take
   logic                     drive_q;
   logic [MEM_NUM_LANES-1:0] be_q;

   // remaining latency stages, index 0 is the first after the lanes
   logic [MEM_DATA_W-1:0]    data_pipe  [MEM_READ_LATENCY-1];
   logic                     drive_pipe [MEM_READ_LATENCY-1];
   logic [MEM_NUM_LANES-1:0] be_pipe    [MEM_READ_LATENCY-1];

   // byte enables expanded to one bit per data bit
   logic [MEM_DATA_W-1:0]    data_mask;

   // ----------------------------------------
   // alignment with the lane registers
   // ----------------------------------------

   always_ff @(posedge clk or posedge internal_reset) begin
      if (internal_reset) begin
         drive_q <= 1'b0;
         be_q    <= '0;
      end else begin
         drive_q <= rd_drive;
         be_q    <= lane_be;
      end
   end

   // ----------------------------------------
   // latency shift register
   // ----------------------------------------

   // data, drive flag and enables move together every cycle
   // an idle cycle pushes a cleared flag, which is what keeps valid low
   always_ff @(posedge clk or posedge internal_reset) begin
      if (internal_reset) begin
         for (int i = 0; i < MEM_READ_LATENCY - 1; i++) begin
            data_pipe[i]  <= '0;
            drive_pipe[i] <= 1'b0;
            be_pipe[i]    <= '0;
         end
      end else begin
         data_pipe[0]  <= lane_rd_data;
         drive_pipe[0] <= drive_q;
         be_pipe[0]    <= be_q;
         for (int i = 1; i < MEM_READ_LATENCY - 1; i++) begin
            data_pipe[i]  <= data_pipe[i-1];
            drive_pipe[i] <= drive_pipe[i-1];
            be_pipe[i]    <= be_pipe[i-1];
         end
      end
   end

   // ----------------------------------------
   // output masking
   // ----------------------------------------

   // widen each enable bit over its lane
   always_comb begin
      for (int l = 0; l < MEM_NUM_LANES; l++) begin
         data_mask[l*MEM_LANE_W +: MEM_LANE_W] = {MEM_LANE_W{be_pipe[MEM_READ_LATENCY-2][l]}};
      end
   end

   // disabled lanes read as zero, the whole word is zero without the flag
   assign rd_valid = drive_pipe[MEM_READ_LATENCY-2];
   assign rd_data  = rd_valid ? (data_pipe[MEM_READ_LATENCY-2] & data_mask) : '0;

   // ----------------------------------------
   // checks
   // ----------------------------------------

   // a driven read comes out after the full latency, lane edge included
   a_read_latency: assert property (
      @(posedge clk) disable iff (internal_reset)
      rd_drive |-> ##MEM_READ_LATENCY rd_valid
   ) else $error("driven read did not reach the output after the read latency");

endmodule

`default_nettype wire

/* ext_mem_byte_lane.sv */
// byte lane: one byte-wide storage array with masked write and registered read
`timescale 1ns/1ps
`default_nettype none

module ext_mem_byte_lane (
   input  wire logic                                  clk,
   input  wire logic                                  internal_reset,
   input  wire logic [ext_mem_pkg::MEM_WORD_ADDR_W-1:0] word_addr,
   input  wire logic                                  we,
   input  wire logic                                  re,
   input  wire logic [ext_mem_pkg::MEM_LANE_W-1:0]    wr_byte,
   output logic      [ext_mem_pkg::MEM_LANE_W-1:0]    rd_byte
);

   import ext_mem_pkg::*;

   // one byte per word of the memory
   logic [MEM_LANE_W-1:0] mem [MEM_NUM_WORDS];

   // ----------------------------------------
   // storage
   // ----------------------------------------

   // whole array is cleared on reset so reads start at zero
   // write lands at the accepting edge
   always_ff @(posedge clk or posedge internal_reset) begin
      if (internal_reset) begin
         for (int i = 0; i < MEM_NUM_WORDS; i++) begin
            mem[i] <= '0;
         end
      end else if (we) begin
         mem[word_addr] <= wr_byte;
      end
   end

   // ----------------------------------------
   // read register
   // ----------------------------------------

   // addressed byte is ready one edge after the read
   // a write in the previous cycle is already in the array by then
   always_ff @(posedge clk or posedge internal_reset) begin
      if (internal_reset) begin
         rd_byte <= '0;
      end else if (re) begin
         rd_byte <= mem[word_addr];
      end
      // otherwise keep the last byte, the pipeline ignores it
   end

   // ----------------------------------------
   // checks
   // ----------------------------------------

   // decoder hands out a single operation per cycle
   // so a lane never sees a write and a read together
   a_we_re_exclusive: assert property (
      @(posedge clk) disable iff (internal_reset)
      !(we && re)
   ) else $error("byte lane saw write and read in one cycle");

endmodule

`default_nettype wire

/* ext_mem_bus_decode.sv */
// bus decoder: pin polarity correction, operation decode and word address
`timescale 1ns/1ps
`default_nettype none

module ext_mem_bus_decode (
   input  wire logic [ext_mem_pkg::MEM_ADDR_W-1:0]    bus_address,
   input  wire logic [ext_mem_pkg::MEM_NUM_LANES-1:0] bus_byteenable,
   input  wire logic                                  bus_read,
   input  wire logic                                  bus_write,
   input  wire logic                                  bus_chipselect_n,
   input  wire logic                                  bus_outputenable,
   output ext_mem_pkg::bus_op_t                       op,
   output logic [ext_mem_pkg::MEM_WORD_ADDR_W-1:0]    word_addr,
   output logic [ext_mem_pkg::MEM_NUM_LANES-1:0]      lane_we,
   output logic [ext_mem_pkg::MEM_NUM_LANES-1:0]      lane_be,
   output logic                                       rd_drive
);

   import ext_mem_pkg::*;

   // pins after polarity correction, all active high
   logic                     cs_act;
   logic                     rd_act;
   logic                     wr_act;
   logic                     oe_act;
   logic [MEM_NUM_LANES-1:0] be_act;

   // ----------------------------------------
   // polarity correction
   // ----------------------------------------

   // xor with the active-low flag flips only the inverted pins
   assign cs_act = bus_chipselect_n ^ MEM_CS_ACTIVE_LOW;
   assign rd_act = bus_read ^ MEM_RD_ACTIVE_LOW;
   assign wr_act = bus_write ^ MEM_WR_ACTIVE_LOW;
   assign oe_act = bus_outputenable ^ MEM_OE_ACTIVE_LOW;

   // byte enables share one polarity flag across all lanes
   assign be_act = bus_byteenable ^ {MEM_NUM_LANES{MEM_BE_ACTIVE_LOW}};

   // ----------------------------------------
   // operation decode
   // ----------------------------------------

   // nothing happens without chip select
   // write takes priority when both strobes are up
   always_comb begin
      op = OP_IDLE;
      if (cs_act && wr_act) begin
         op = OP_WRITE;
      end else if (cs_act && rd_act) begin
         op = OP_READ;
      end
   end

   // drop the byte-select bits, the lanes work on whole words
   assign word_addr = bus_address[MEM_ADDR_W-1:MEM_LANE_SEL_W];

   // one write enable per lane, gated by the decoded write
   assign lane_we = (op == OP_WRITE) ? be_act : '0;

   // byte enables travel on for masking the read data
   assign lane_be = be_act;

   // the read only reaches the output when output enable is up
   assign rd_drive = (op == OP_READ) && oe_act;

endmodule

`default_nettype wire

/* ext_mem_pkg.sv */
// memory geometry, read latency, pin polarities and the bus-operation opcode
`default_nettype none

package ext_mem_pkg;

   // ----------------------------------------
   // geometry
   // ----------------------------------------

   // byte address as seen on the bus
   localparam int MEM_ADDR_W = 10;

   // four byte lanes of eight bits each
   localparam int MEM_NUM_LANES = 4;
   localparam int MEM_LANE_W = 8;

   // full word width, one lane per byte
   localparam int MEM_DATA_W = MEM_NUM_LANES * MEM_LANE_W;

   // low address bits select a byte inside the word
   localparam int MEM_LANE_SEL_W = 2;

   // what is left of the address picks the word
   localparam int MEM_WORD_ADDR_W = MEM_ADDR_W - MEM_LANE_SEL_W;

   // depth of each lane array
   localparam int MEM_NUM_WORDS = 2 ** MEM_WORD_ADDR_W;

   // ----------------------------------------
   // timing
   // ----------------------------------------

   // rising edges from an accepted read to valid data
   // one edge in the lane array, the rest in the read pipeline
   localparam int MEM_READ_LATENCY = 3;

   // ----------------------------------------
   // pin polarity
   // ----------------------------------------

   // chip select is the only active-low pin on this part
   localparam bit MEM_CS_ACTIVE_LOW = 1'b1;
   localparam bit MEM_RD_ACTIVE_LOW = 1'b0;
   localparam bit MEM_WR_ACTIVE_LOW = 1'b0;
   localparam bit MEM_BE_ACTIVE_LOW = 1'b0;
   localparam bit MEM_OE_ACTIVE_LOW = 1'b0;

   // ----------------------------------------
   // bus operation
   // ----------------------------------------

   // one operation per cycle, write wins over read
   typedef enum logic [1:0] {
      OP_IDLE,
      OP_READ,
      OP_WRITE
   } bus_op_t;

endpackage

`default_nettype wire
